/* tb.f */
+incdir+rtl
rtl/io_link_pkg.sv
rtl/io_req_decode.sv
rtl/sdr_link_tx.sv
rtl/sdr_link_rx.sv
rtl/io_return_format.sv
rtl/io_link_top.sv
sim/io_link_assertions.sv
sim/io_link_tb.sv

/* sim/io_link_tb.sv */
`timescale 1ns/10ps

`include "io_link_config.svh"

module io_link_tb
  import io_link_pkg::*;
  ();

  localparam int                    seed_lp      = 25;
  localparam int                    num_txn_lp   = 122;  // 2 + 16 + 60 + 24 + 20
  localparam logic [`IO_ADDR_W-1:0] base_addr_lp = 12'h3c0;

  logic               core_clk_i;
  logic               arst_n_i;
  logic [`IO_X_W-1:0] global_x_i;
  logic [`IO_Y_W-1:0] global_y_i;
  logic               mesh_fwd_v_i;
  io_fwd_packet_s     mesh_fwd_data_i;
  logic               mesh_fwd_ready_o;
  logic               mesh_rev_v_o;
  io_return_packet_s  mesh_rev_data_o;
  logic               mesh_rev_ready_i;
  logic               link_fwd_v_o;
  io_fwd_packet_s     link_fwd_data_o;
  logic               link_fwd_token_i;
  logic               link_rev_v_i;
  io_rev_word_s       link_rev_data_i;
  logic               link_rev_token_o;

  io_return_packet_s     exp_q[$];
  io_rev_word_s          reply_q[$];
  int                    reply_due_q[$];
  logic [`IO_DATA_W-1:0] shadow_mem [logic [`IO_ADDR_W-1:0]];  // Memory as seen at issue
  logic [`IO_DATA_W-1:0] model_mem  [logic [`IO_ADDR_W-1:0]];
  logic [31:0]           stim_rng;
  int                    issued;
  int                    returned;
  int                    fwd_words;
  bit                    stall_rev;
  bit                    hold_tokens;

  io_link_top i_io_link_top
  (.core_clk_i      (core_clk_i)
  ,.arst_n_i        (arst_n_i)
  ,.global_x_i      (global_x_i)
  ,.global_y_i      (global_y_i)
  ,.mesh_fwd_v_i    (mesh_fwd_v_i)
  ,.mesh_fwd_data_i (mesh_fwd_data_i)
  ,.mesh_fwd_ready_o(mesh_fwd_ready_o)
  ,.mesh_rev_v_o    (mesh_rev_v_o)
  ,.mesh_rev_data_o (mesh_rev_data_o)
  ,.mesh_rev_ready_i(mesh_rev_ready_i)
  ,.link_fwd_v_o    (link_fwd_v_o)
  ,.link_fwd_data_o (link_fwd_data_o)
  ,.link_fwd_token_i(link_fwd_token_i)
  ,.link_rev_v_i    (link_rev_v_i)
  ,.link_rev_data_i (link_rev_data_i)
  ,.link_rev_token_o(link_rev_token_o)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Helpers and reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [31:0] lcg_next(inout logic [31:0] state);
    state = state * 32'd1664525 + 32'd1013904223;
    return {8'h00, state[31:8]};  // Low LCG bits repeat too quickly
  endfunction

  function automatic logic [31:0] fill_word(input logic [`IO_ADDR_W-1:0] addr);
    return {addr, 8'h5a, addr ^ 12'h9c3};
  endfunction

  function automatic io_return_packet_s ref_return(input io_op_e op, input io_load_info_s info,
      input logic [31:0] word, input logic [`IO_X_W-1:0] req_x, input logic [`IO_Y_W-1:0] req_y);
    io_return_packet_s pkt;
    int                nbytes;
    int                off;
    pkt        = '0;
    pkt.op     = op;
    pkt.dest_x = req_x;
    pkt.dest_y = req_y;
    pkt.src_x  = global_x_i;
    pkt.src_y  = global_y_i;
    if (op == IO_OP_LOAD)
    begin
      pkt.reg_id = info.reg_id;
      nbytes     = (info.size == IO_SIZE_BYTE) ? 1 : (info.size == IO_SIZE_HALF) ? 2 : 4;
      off        = info.byte_offset;
      for (int i = 0; i < 4; i++)
      begin
        if (i < nbytes && off + i < 4)
          pkt.data[8*i +: 8] = word[8*(off+i) +: 8];
        else if (i >= nbytes && info.is_signed && pkt.data[8*nbytes-1])
          pkt.data[8*i +: 8] = 8'hff;
      end
    end
    return pkt;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [63:0] exp_val,
                             input logic [63:0] got_val);
    if (exp_val !== got_val)
      abort_run($sformatf("mismatch %s exp %h got %h", name, exp_val, got_val));
  endtask

  task automatic send_req(input io_op_e op, input logic [`IO_ADDR_W-1:0] addr,
                          input logic [31:0] payload);
    io_fwd_packet_s pkt;
    logic [31:0]    r;
    logic [31:0]    word;
    r                = lcg_next(stim_rng);
    pkt.op           = op;
    pkt.addr         = addr;
    pkt.payload.data = payload;
    pkt.src_x        = r[3:0];
    pkt.src_y        = r[6:4];
    mesh_fwd_v_i     = 1'b1;
    mesh_fwd_data_i  = pkt;
    do
      @(posedge core_clk_i);
    while (!mesh_fwd_ready_o);
    word = shadow_mem.exists(addr) ? shadow_mem[addr] : fill_word(addr);
    if (op == IO_OP_STORE)
      shadow_mem[addr] = payload;
    exp_q.push_back(ref_return(op, pkt.payload.load.info, word, pkt.src_x, pkt.src_y));
    issued++;
    #1;
    mesh_fwd_v_i = 1'b0;
  endtask

  task automatic send_load(input logic [`IO_ADDR_W-1:0] addr, input logic is_signed,
                           input logic [1:0] size, input logic [1:0] offset);
    io_load_info_s info;
    logic [31:0]   r;
    r                = lcg_next(stim_rng);
    info.is_signed   = is_signed;
    info.size        = size;
    info.byte_offset = offset;
    info.reg_id      = r[4:0];
    send_req(IO_OP_LOAD, addr, {r[23:2], info});  // Junk padding, decode must clear it
  endtask

  task automatic send_random();
    logic [31:0] r;
    logic [31:0] d;
    logic [1:0]  size;
    r    = lcg_next(stim_rng);
    d    = (lcg_next(stim_rng) << 8) ^ lcg_next(stim_rng);
    size = (r[11:10] == 2'd3) ? IO_SIZE_WORD : r[11:10];
    if (r[8])
      send_req(IO_OP_STORE, base_addr_lp + r[3:0], d);
    else
      send_load(base_addr_lp + r[3:0], r[9], size, r[13:12]);
  endtask

  task automatic watch_fwd_block();
    int blocked;
    blocked = 0;
    while (blocked < 16)
    begin
      @(posedge core_clk_i);
      if (mesh_fwd_v_i && !mesh_fwd_ready_o)
        blocked++;
      else
        blocked = 0;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Clock, stimulus and checking
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial
  begin
    core_clk_i = 1'b0;
    forever
      #4 core_clk_i = ~core_clk_i;
  end

  initial
  begin
    stim_rng        = seed_lp;
    issued          = 0;
    arst_n_i        = 1'b1;
    global_x_i      = 4'h5;
    global_y_i      = 3'h6;
    mesh_fwd_v_i    = 1'b0;
    mesh_fwd_data_i = '0;
    stall_rev       = 1'b0;
    hold_tokens     = 1'b0;
    #1;
    arst_n_i = 1'b0;
    repeat (3) @(posedge core_clk_i);
    #1;
    arst_n_i = 1'b1;
    send_req(IO_OP_STORE, base_addr_lp + 12'd5, 32'h8a7f_c312);
    send_load(base_addr_lp + 12'd5, 1'b0, IO_SIZE_WORD, 2'd0);
    for (int sz = 0; sz < 2; sz++)
      for (int off = 0; off < 4; off++)
        for (int sgn = 0; sgn < 2; sgn++)
          send_load(base_addr_lp + 12'd5, sgn[0], sz[1:0], off[1:0]);
    repeat (60) send_random();
    stall_rev = 1'b1;  // Hold returns until the mesh input backs up
    fork
      repeat (24) send_random();
      begin
        watch_fwd_block();
        stall_rev = 1'b0;
      end
    join
    hold_tokens = 1'b1;
    fork
      repeat (20) send_random();
      begin
        repeat (60) @(posedge core_clk_i);
        hold_tokens = 1'b0;
      end
    join
    while (returned != issued)
      @(posedge core_clk_i);
    repeat (8) @(posedge core_clk_i);
    check_value("link_fwd_v_o words", issued, fwd_words);
    if (i_io_link_top.i_sdr_link_tx.i_tx_assertions.failed ||
        i_io_link_top.i_sdr_link_rx.i_rx_assertions.failed)
      abort_run("a link assertion failed");
    else
    begin
      $display("TEST PASS");
      $finish;
    end
  end

  initial
  begin
    logic [31:0] rng;
    logic [31:0] r;
    rng              = seed_lp + 1;
    mesh_rev_ready_i = 1'b0;
    forever
    begin
      @(posedge core_clk_i);
      r = lcg_next(rng);
      #1;
      mesh_rev_ready_i = !stall_rev && (r[5:4] != 2'b00);
    end
  end

  // Off-chip memory behind the link
  initial
  begin
    logic [31:0]    rng;
    io_fwd_packet_s pkt;
    io_rev_word_s   reply;
    int             cycle;
    int             owed;
    int             rev_credit;
    rng              = seed_lp + 2;
    cycle            = 0;
    fwd_words        = 0;
    owed             = 0;
    rev_credit       = 1 << `IO_LG_FIFO_DEPTH;
    link_fwd_token_i = 1'b0;
    link_rev_v_i     = 1'b0;
    link_rev_data_i  = '0;
    forever
    begin
      @(posedge core_clk_i);
      cycle++;
      if (link_fwd_v_o)
      begin
        pkt      = link_fwd_data_o;
        reply.op = pkt.op;
        if (pkt.op == IO_OP_STORE)
        begin
          model_mem[pkt.addr] = pkt.payload.data;
          reply.data          = pkt.payload.data;  // Format has to zero this
        end
        else
        begin
          check_value("link_fwd_data_o.payload.load.pad", '0, pkt.payload.load.pad);
          reply.data = model_mem.exists(pkt.addr) ? model_mem[pkt.addr] : fill_word(pkt.addr);
        end
        reply_q.push_back(reply);
        reply_due_q.push_back(cycle + 1 + (lcg_next(rng) % 4));
        fwd_words++;
        if (fwd_words % (1 << `IO_LG_TOKEN_DEC) == 0)
          owed++;
      end
      if (link_rev_token_o)
        rev_credit += 1 << `IO_LG_TOKEN_DEC;
      #1;
      link_fwd_token_i = !hold_tokens && (owed > 0);
      if (link_fwd_token_i)
        owed--;
      link_rev_v_i = (reply_q.size() > 0) && (reply_due_q[0] <= cycle) && (rev_credit > 0);
      if (link_rev_v_i)
      begin
        link_rev_data_i = reply_q.pop_front();
        void'(reply_due_q.pop_front());
        rev_credit--;
      end
    end
  end

  initial
  begin
    io_return_packet_s exp_pkt;
    returned = 0;
    forever
    begin
      @(posedge core_clk_i);
      if (i_io_link_top.i_sdr_link_tx.i_tx_assertions.failed ||
          i_io_link_top.i_sdr_link_rx.i_rx_assertions.failed)
        abort_run("a link credit or FIFO assertion failed");
      if (mesh_rev_v_o && mesh_rev_ready_i)
      begin
        if (exp_q.size() == 0)
          abort_run("return packet arrived with no request outstanding");
        exp_pkt = exp_q.pop_front();
        check_value("mesh_rev_data_o.op", exp_pkt.op, mesh_rev_data_o.op);
        check_value("mesh_rev_data_o.reg_id", exp_pkt.reg_id, mesh_rev_data_o.reg_id);
        check_value("mesh_rev_data_o.data", exp_pkt.data, mesh_rev_data_o.data);
        check_value("mesh_rev_data_o.dest_x", exp_pkt.dest_x, mesh_rev_data_o.dest_x);
        check_value("mesh_rev_data_o.dest_y", exp_pkt.dest_y, mesh_rev_data_o.dest_y);
        check_value("mesh_rev_data_o.src_x", exp_pkt.src_x, mesh_rev_data_o.src_x);
        check_value("mesh_rev_data_o.src_y", exp_pkt.src_y, mesh_rev_data_o.src_y);
        returned++;
      end
    end
  end

  initial
  begin
    repeat (num_txn_lp * 64) @(posedge core_clk_i);
    abort_run("run timed out before all returns arrived");
  end

endmodule

/* sim/io_link_assertions.sv */
`timescale 1ns/10ps

`include "io_link_config.svh"

module io_link_assertions
  #(parameter int cnt_w_p = `IO_LG_FIFO_DEPTH + 1)
  (input  logic               core_clk_i
  ,input  logic               arst_n_i
  ,input  logic               link_out_i  // Link output that must stay quiet in reset
  ,input  logic [cnt_w_p-1:0] credit_i
  ,input  logic               push_i
  ,input  logic               pop_i
  ,input  logic [cnt_w_p-1:0] count_i
  );

  localparam int depth_lp = 1 << `IO_LG_FIFO_DEPTH;

  bit failed;

  // Tokens never hand back more credits than the far FIFO holds
  credit_a: assert property (@(posedge core_clk_i) disable iff (!arst_n_i)
    credit_i <= depth_lp)
    else
    begin
      failed = 1'b1;
      $error("link credit count above the far FIFO depth");
    end

  overflow_a: assert property (@(posedge core_clk_i) disable iff (!arst_n_i)
    (push_i && !pop_i) |-> (count_i < depth_lp))
    else
    begin
      failed = 1'b1;
      $error("link FIFO written while full");
    end

  reset_quiet_a: assert property (@(posedge core_clk_i) !arst_n_i |-> !link_out_i)
    else
    begin
      failed = 1'b1;
      $error("link output active during reset");
    end

endmodule

bind sdr_link_tx io_link_assertions i_tx_assertions
  (.core_clk_i(core_clk_i)
  ,.arst_n_i  (arst_n_i)
  ,.link_out_i(link_v_o)
  ,.credit_i  (credit_r)
  ,.push_i    (enq)
  ,.pop_i     (deq)
  ,.count_i   (count_r)
  );

bind sdr_link_rx io_link_assertions i_rx_assertions
  (.core_clk_i(core_clk_i)
  ,.arst_n_i  (arst_n_i)
  ,.link_out_i(link_token_o)
  ,.credit_i  ('0)
  ,.push_i    (link_v_i)
  ,.pop_i     (core_yumi_i)
  ,.count_i   (count_r)
  );

/* rtl/io_link_top.sv */
`timescale 1ns/10ps

`include "io_link_config.svh"

module io_link_top
  import io_link_pkg::*;
  (input  logic               core_clk_i
  ,input  logic               arst_n_i

  ,input  logic [`IO_X_W-1:0] global_x_i
  ,input  logic [`IO_Y_W-1:0] global_y_i

  ,input  logic               mesh_fwd_v_i
  ,input  io_fwd_packet_s     mesh_fwd_data_i
  ,output logic               mesh_fwd_ready_o

  ,output logic               mesh_rev_v_o
  ,output io_return_packet_s  mesh_rev_data_o
  ,input  logic               mesh_rev_ready_i

  ,output logic               link_fwd_v_o
  ,output io_fwd_packet_s     link_fwd_data_o
  ,input  logic               link_fwd_token_i

  ,input  logic               link_rev_v_i
  ,input  io_rev_word_s       link_rev_data_i
  ,output logic               link_rev_token_o
  );

  logic               tx_v;
  io_fwd_packet_s     tx_data;
  logic               tx_ready;
  logic               pend_v;
  io_op_e             pend_op;
  io_load_info_s      pend_info;
  logic [`IO_X_W-1:0] pend_src_x;
  logic [`IO_Y_W-1:0] pend_src_y;
  logic               pend_ready;
  logic               rx_v;
  io_rev_word_s       rx_data;
  logic               rx_yumi;

  io_req_decode i_io_req_decode
  (.core_clk_i      (core_clk_i)
  ,.arst_n_i        (arst_n_i)
  ,.mesh_fwd_v_i    (mesh_fwd_v_i)
  ,.mesh_fwd_data_i (mesh_fwd_data_i)
  ,.mesh_fwd_ready_o(mesh_fwd_ready_o)
  ,.tx_v_o          (tx_v)
  ,.tx_data_o       (tx_data)
  ,.tx_ready_i      (tx_ready)
  ,.pend_v_o        (pend_v)
  ,.pend_op_o       (pend_op)
  ,.pend_info_o     (pend_info)
  ,.pend_src_x_o    (pend_src_x)
  ,.pend_src_y_o    (pend_src_y)
  ,.pend_ready_i    (pend_ready)
  );

  sdr_link_tx
 #(.width_p($bits(io_fwd_packet_s))
  ) i_sdr_link_tx
  (.core_clk_i  (core_clk_i)
  ,.arst_n_i    (arst_n_i)
  ,.core_v_i    (tx_v)
  ,.core_data_i (tx_data)
  ,.core_ready_o(tx_ready)
  ,.link_v_o    (link_fwd_v_o)
  ,.link_data_o (link_fwd_data_o)
  ,.link_token_i(link_fwd_token_i)
  );

  sdr_link_rx
 #(.width_p($bits(io_rev_word_s))
  ) i_sdr_link_rx
  (.core_clk_i  (core_clk_i)
  ,.arst_n_i    (arst_n_i)
  ,.link_v_i    (link_rev_v_i)
  ,.link_data_i (link_rev_data_i)
  ,.link_token_o(link_rev_token_o)
  ,.core_v_o    (rx_v)
  ,.core_data_o (rx_data)
  ,.core_yumi_i (rx_yumi)
  );

  io_return_format i_io_return_format
  (.core_clk_i      (core_clk_i)
  ,.arst_n_i        (arst_n_i)
  ,.global_x_i      (global_x_i)
  ,.global_y_i      (global_y_i)
  ,.pend_v_i        (pend_v)
  ,.pend_op_i       (pend_op)
  ,.pend_info_i     (pend_info)
  ,.pend_src_x_i    (pend_src_x)
  ,.pend_src_y_i    (pend_src_y)
  ,.pend_ready_o    (pend_ready)
  ,.rx_v_i          (rx_v)
  ,.rx_data_i       (rx_data)
  ,.rx_yumi_o       (rx_yumi)
  ,.mesh_rev_v_o    (mesh_rev_v_o)
  ,.mesh_rev_data_o (mesh_rev_data_o)
  ,.mesh_rev_ready_i(mesh_rev_ready_i)
  );

endmodule

/* rtl/io_return_format.sv */
`timescale 1ns/10ps

`include "io_link_config.svh"

module io_return_format
  import io_link_pkg::*;
  (input  logic               core_clk_i
  ,input  logic               arst_n_i

  ,input  logic [`IO_X_W-1:0] global_x_i
  ,input  logic [`IO_Y_W-1:0] global_y_i

  ,input  logic               pend_v_i
  ,input  io_op_e             pend_op_i
  ,input  io_load_info_s      pend_info_i
  ,input  logic [`IO_X_W-1:0] pend_src_x_i
  ,input  logic [`IO_Y_W-1:0] pend_src_y_i
  ,output logic               pend_ready_o

  ,input  logic               rx_v_i
  ,input  io_rev_word_s       rx_data_i
  ,output logic               rx_yumi_o

  ,output logic               mesh_rev_v_o
  ,output io_return_packet_s  mesh_rev_data_o
  ,input  logic               mesh_rev_ready_i
  );

  localparam logic [`IO_LG_FIFO_DEPTH:0] depth_lp = 1 << `IO_LG_FIFO_DEPTH;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Pending queue
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  io_op_e                       op_mem_r    [depth_lp];
  io_load_info_s                info_mem_r  [depth_lp];
  logic [`IO_X_W-1:0]           src_x_mem_r [depth_lp];
  logic [`IO_Y_W-1:0]           src_y_mem_r [depth_lp];
  logic [`IO_LG_FIFO_DEPTH-1:0] wptr_r;
  logic [`IO_LG_FIFO_DEPTH-1:0] rptr_r;
  logic [`IO_LG_FIFO_DEPTH:0]   count_r;
  logic                         enq;
  logic                         deq;

  assign pend_ready_o = (count_r != depth_lp);
  assign enq          = pend_v_i & pend_ready_o;
  assign mesh_rev_v_o = rx_v_i & (count_r != '0);
  assign rx_yumi_o    = mesh_rev_v_o & mesh_rev_ready_i;
  assign deq          = rx_yumi_o;  // Both queues pop together

  always_ff @(posedge core_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wptr_r  <= '0;
      rptr_r  <= '0;
      count_r <= '0;
    end
    else
    begin
      if (enq)
        wptr_r <= wptr_r + 1'b1;
      if (deq)
        rptr_r <= rptr_r + 1'b1;
      case ({enq, deq})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    if (enq)
    begin
      op_mem_r[wptr_r]    <= pend_op_i;
      info_mem_r[wptr_r]  <= pend_info_i;
      src_x_mem_r[wptr_r] <= pend_src_x_i;
      src_y_mem_r[wptr_r] <= pend_src_y_i;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Load extraction
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  io_op_e                head_op;
  io_load_info_s         head_info;
  logic [`IO_DATA_W-1:0] shifted;
  logic [`IO_DATA_W-1:0] load_data;
  logic                  byte_sign;
  logic                  half_sign;

  assign head_op   = op_mem_r[rptr_r];
  assign head_info = info_mem_r[rptr_r];
  assign shifted   = rx_data_i.data >> {head_info.byte_offset, 3'b000};
  assign byte_sign = head_info.is_signed & shifted[7];
  assign half_sign = head_info.is_signed & shifted[15];

  always_comb
  begin
    case (head_info.size)
      IO_SIZE_BYTE: load_data = {{(`IO_DATA_W-8){byte_sign}}, shifted[7:0]};
      IO_SIZE_HALF: load_data = {{(`IO_DATA_W-16){half_sign}}, shifted[15:0]};
      default:      load_data = shifted;
    endcase
  end

  always_comb
  begin
    mesh_rev_data_o.op     = head_op;
    mesh_rev_data_o.reg_id = head_info.reg_id;  // Zero for stores
    mesh_rev_data_o.data   = (head_op == IO_OP_LOAD) ? load_data : '0;
    mesh_rev_data_o.dest_x = src_x_mem_r[rptr_r];
    mesh_rev_data_o.dest_y = src_y_mem_r[rptr_r];
    mesh_rev_data_o.src_x  = global_x_i;
    mesh_rev_data_o.src_y  = global_y_i;
  end

endmodule

/* rtl/sdr_link_rx.sv */
`timescale 1ns/10ps

`include "io_link_config.svh"

module sdr_link_rx
  #(parameter width_p = 8)
  (input  logic               core_clk_i
  ,input  logic               arst_n_i

  ,input  logic               link_v_i
  ,input  logic [width_p-1:0] link_data_i
  ,output logic               link_token_o

  ,output logic               core_v_o
  ,output logic [width_p-1:0] core_data_o
  ,input  logic               core_yumi_i
  );

  localparam logic [`IO_LG_FIFO_DEPTH:0] depth_lp = 1 << `IO_LG_FIFO_DEPTH;

  logic [width_p-1:0]           mem_r [depth_lp];
  logic [`IO_LG_FIFO_DEPTH-1:0] wptr_r;
  logic [`IO_LG_FIFO_DEPTH-1:0] rptr_r;
  logic [`IO_LG_FIFO_DEPTH:0]   count_r;
  logic [`IO_LG_TOKEN_DEC-1:0]  deq_cnt_r;
  logic                         token_r;

  assign core_v_o     = (count_r != '0);
  assign core_data_o  = mem_r[rptr_r];
  assign link_token_o = token_r;

  always_ff @(posedge core_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wptr_r    <= '0;
      rptr_r    <= '0;
      count_r   <= '0;
      deq_cnt_r <= '0;
      token_r   <= 1'b0;
    end
    else
    begin
      token_r <= core_yumi_i & (&deq_cnt_r);  // Last dequeue of a group
      if (link_v_i)
        wptr_r <= wptr_r + 1'b1;
      if (core_yumi_i)
      begin
        rptr_r    <= rptr_r + 1'b1;
        deq_cnt_r <= deq_cnt_r + 1'b1;
      end
      case ({link_v_i, core_yumi_i})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  // The sender holds credits, so every word finds a free entry
  always_ff @(posedge core_clk_i)
  begin
    if (link_v_i)
      mem_r[wptr_r] <= link_data_i;
  end

endmodule

/* rtl/sdr_link_tx.sv */
`timescale 1ns/10ps

`include "io_link_config.svh"

module sdr_link_tx
  #(parameter width_p = 8)
  (input  logic               core_clk_i
  ,input  logic               arst_n_i

  ,input  logic               core_v_i
  ,input  logic [width_p-1:0] core_data_i
  ,output logic               core_ready_o

  ,output logic               link_v_o
  ,output logic [width_p-1:0] link_data_o
  ,input  logic               link_token_i
  );

  localparam logic [`IO_LG_FIFO_DEPTH:0] depth_lp = 1 << `IO_LG_FIFO_DEPTH;
  localparam logic [`IO_LG_FIFO_DEPTH:0] dec_lp   = 1 << `IO_LG_TOKEN_DEC;

  logic [width_p-1:0]           mem_r [depth_lp];
  logic [`IO_LG_FIFO_DEPTH-1:0] wptr_r;
  logic [`IO_LG_FIFO_DEPTH-1:0] rptr_r;
  logic [`IO_LG_FIFO_DEPTH:0]   count_r;
  logic [`IO_LG_FIFO_DEPTH:0]   credit_r;
  logic [`IO_LG_FIFO_DEPTH:0]   credit_next;
  logic                         enq;
  logic                         deq;

  assign core_ready_o = (count_r != depth_lp);
  assign enq          = core_v_i & core_ready_o;
  assign link_v_o     = (count_r != '0) & (credit_r != '0);  // One credit per word sent
  assign deq          = link_v_o;
  assign link_data_o  = mem_r[rptr_r];

  always_comb
  begin
    credit_next = credit_r;
    if (link_token_i)
      credit_next = credit_next + dec_lp;
    if (deq)
      credit_next = credit_next - 1'b1;
  end

  always_ff @(posedge core_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wptr_r   <= '0;
      rptr_r   <= '0;
      count_r  <= '0;
      credit_r <= depth_lp;  // Far side starts with an empty FIFO
    end
    else
    begin
      credit_r <= credit_next;
      if (enq)
        wptr_r <= wptr_r + 1'b1;
      if (deq)
        rptr_r <= rptr_r + 1'b1;
      case ({enq, deq})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    if (enq)
      mem_r[wptr_r] <= core_data_i;
  end

endmodule

/* rtl/io_req_decode.sv */
`timescale 1ns/10ps

`include "io_link_config.svh"

module io_req_decode
  import io_link_pkg::*;
  (input  logic               core_clk_i
  ,input  logic               arst_n_i

  ,input  logic               mesh_fwd_v_i
  ,input  io_fwd_packet_s     mesh_fwd_data_i
  ,output logic               mesh_fwd_ready_o

  ,output logic               tx_v_o
  ,output io_fwd_packet_s     tx_data_o
  ,input  logic               tx_ready_i

  ,output logic               pend_v_o
  ,output io_op_e             pend_op_o
  ,output io_load_info_s      pend_info_o
  ,output logic [`IO_X_W-1:0] pend_src_x_o
  ,output logic [`IO_Y_W-1:0] pend_src_y_o
  ,input  logic               pend_ready_i
  );

  io_fwd_packet_s fwd_clean;
  io_fwd_packet_s slot_r;
  logic           slot_v_r;
  logic           drain;

  // Loads leave with a canonical payload, only the info bits may be set
  always_comb
  begin
    fwd_clean = mesh_fwd_data_i;
    if (mesh_fwd_data_i.op == IO_OP_LOAD)
      fwd_clean.payload.load.pad = '0;
  end

  assign drain            = slot_v_r & tx_ready_i & pend_ready_i;
  assign mesh_fwd_ready_o = ~slot_v_r | drain;

  always_ff @(posedge core_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      slot_v_r <= 1'b0;
    else if (mesh_fwd_ready_o)
      slot_v_r <= mesh_fwd_v_i;
  end

  always_ff @(posedge core_clk_i)
  begin
    if (mesh_fwd_ready_o & mesh_fwd_v_i)
      slot_r <= fwd_clean;
  end

  // Each side only sees valid when the other can take it too
  assign tx_v_o    = slot_v_r & pend_ready_i;
  assign tx_data_o = slot_r;

  assign pend_v_o     = slot_v_r & tx_ready_i;
  assign pend_op_o    = slot_r.op;
  assign pend_info_o  = (slot_r.op == IO_OP_LOAD) ? slot_r.payload.load.info : '0;
  assign pend_src_x_o = slot_r.src_x;
  assign pend_src_y_o = slot_r.src_y;

endmodule

/* rtl/io_link_pkg.sv */
`include "io_link_config.svh"

package io_link_pkg;

  typedef enum logic [0:0]
  {
    IO_OP_LOAD  = 1'b0
   ,IO_OP_STORE = 1'b1
  } io_op_e;

  // Load size encodings
  localparam logic [1:0] IO_SIZE_BYTE = 2'd0;
  localparam logic [1:0] IO_SIZE_HALF = 2'd1;
  localparam logic [1:0] IO_SIZE_WORD = 2'd2;

  typedef struct packed
  {
    logic                 is_signed;
    logic [1:0]           size;
    logic [1:0]           byte_offset;
    logic [`IO_REG_W-1:0] reg_id;
  } io_load_info_s;

  typedef struct packed
  {
    logic [`IO_DATA_W-$bits(io_load_info_s)-1:0] pad;
    io_load_info_s                               info;
  } io_load_word_s;

  // Store data or load info, selected by the op of the packet
  typedef union packed
  {
    logic [`IO_DATA_W-1:0] data;
    io_load_word_s         load;
  } io_payload_u;

  typedef struct packed
  {
    io_op_e                op;
    logic [`IO_ADDR_W-1:0] addr;
    io_payload_u           payload;
    logic [`IO_X_W-1:0]    src_x;
    logic [`IO_Y_W-1:0]    src_y;
  } io_fwd_packet_s;

  typedef struct packed
  {
    io_op_e                op;  // Echo of the request op
    logic [`IO_DATA_W-1:0] data;
  } io_rev_word_s;

  typedef struct packed
  {
    io_op_e                op;
    logic [`IO_REG_W-1:0]  reg_id;
    logic [`IO_DATA_W-1:0] data;
    logic [`IO_X_W-1:0]    dest_x;
    logic [`IO_Y_W-1:0]    dest_y;
    logic [`IO_X_W-1:0]    src_x;
    logic [`IO_Y_W-1:0]    src_y;
  } io_return_packet_s;

endpackage

/* rtl/io_link_config.svh */
`ifndef IO_LINK_CONFIG_SVH
`define IO_LINK_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Packet field widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define IO_ADDR_W        12  // Word address
`define IO_DATA_W        32
`define IO_X_W           4
`define IO_Y_W           3
`define IO_REG_W         5

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Link sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define IO_LG_FIFO_DEPTH 3  // Also sizes the pending queue
`define IO_LG_TOKEN_DEC  1  // One token stands for 2**this dequeues

`endif
